// File: rtl/ldq_defs.svh
`ifndef LDQ_DEFS_SVH
`define LDQ_DEFS_SVH

// Load queue depth.
`define LDQ_NUM_ENTRIES 8

// Reorder buffer id width.
`define ROB_ID_W 6

// Physical register file index width.
`define PDST_W 7

`define XLEN 32 // Data and address width.

// Data memory depth in 32-bit words.
`define DMEM_WORDS 16

`endif

// File: rtl/ldq_pkg.sv
`include "ldq_defs.svh"

package ldq_pkg;

    // Load queue entry index.
    typedef logic [$clog2(`LDQ_NUM_ENTRIES)-1:0] t_ldq_id;

    typedef logic [`ROB_ID_W-1:0] t_rob_id; // Age order, no wrap.

    typedef logic [`PDST_W-1:0] t_pdst;

    // Source values, virtual addresses and load data.
    typedef logic [`XLEN-1:0] t_xdata;

    // Outcome of a load at the last pipe stage.
    typedef enum logic [1:0] {
        act_none,
        act_complete,
        act_fault
    } t_pipe_action;

    // Memory pipe stages.
    typedef enum logic [2:0] {
        mm1,
        mm2,
        mm3,
        mm4,
        mm5
    } t_pipe_stage;

endpackage

// File: rtl/mem_pipe_if.sv
`timescale 1ns/1ps

interface mem_pipe_if;
    import ldq_pkg::*;

    // Request from the load queue arbiter.
    logic         req;
    t_ldq_id      req_ldqid;
    t_rob_id      req_robid;
    t_pdst        req_pdst;
    t_xdata       req_vaddr;

    logic         gnt;

    // Result of the load leaving mm5.
    logic         mm5_valid;
    t_ldq_id      mm5_ldqid;
    t_pipe_action mm5_action;

    modport queue (
        output req, req_ldqid, req_robid, req_pdst, req_vaddr,
        input  gnt, mm5_valid, mm5_ldqid, mm5_action
    );

    modport pipe (
        input  req, req_ldqid, req_robid, req_pdst, req_vaddr,
        output gnt, mm5_valid, mm5_ldqid, mm5_action
    );

endinterface

// File: rtl/find_first_arbiter.sv
`timescale 1ns/1ps
`include "ldq_defs.svh"

module find_first_arbiter (
    input  logic [`LDQ_NUM_ENTRIES-1:0] reqs,
    input  ldq_pkg::t_rob_id            req_robids [`LDQ_NUM_ENTRIES],
    input  ldq_pkg::t_pdst              req_pdsts [`LDQ_NUM_ENTRIES],
    input  ldq_pkg::t_xdata             req_vaddrs [`LDQ_NUM_ENTRIES],
    input  logic                        ext_gnt,
    output logic                        ext_req,
    output ldq_pkg::t_ldq_id            ext_ldqid,
    output ldq_pkg::t_rob_id            ext_robid,
    output ldq_pkg::t_pdst              ext_pdst,
    output ldq_pkg::t_xdata             ext_vaddr,
    output logic [`LDQ_NUM_ENTRIES-1:0] gnts
);
    import ldq_pkg::*;

    logic [`LDQ_NUM_ENTRIES-1:0] first_oh;
    t_ldq_id                     sel;

    // Lowest set bit of the request vector.
    assign first_oh = reqs & (~reqs + `LDQ_NUM_ENTRIES'(1));

    // Walk down so the lowest requester wins.
    always_comb begin
        sel = '0;
        for (int i = `LDQ_NUM_ENTRIES - 1; i >= 0; i--) begin
            if (reqs[i]) begin
                sel = t_ldq_id'(i);
            end
        end
    end

    assign ext_req   = |reqs;
    assign ext_ldqid = sel;
    assign ext_robid = req_robids[sel];
    assign ext_pdst  = req_pdsts[sel];
    assign ext_vaddr = req_vaddrs[sel];

    assign gnts = ext_gnt ? first_oh : '0; // Nothing granted without the pipe.

endmodule

// File: rtl/loadq_entry.sv
`timescale 1ns/1ps

module loadq_entry (
    input  logic             clk,
    input  logic             rst_n,
    input  ldq_pkg::t_ldq_id id,
    input  logic             alloc,
    input  ldq_pkg::t_rob_id alloc_robid,
    input  ldq_pkg::t_pdst   alloc_pdst,
    input  ldq_pkg::t_xdata  alloc_vaddr,
    input  logic             nuke_valid,
    input  ldq_pkg::t_rob_id nuke_robid,
    input  logic             gnt,
    input  logic             mm5_valid,
    input  ldq_pkg::t_ldq_id mm5_ldqid,
    output logic             valid,
    output logic             req,
    output ldq_pkg::t_rob_id req_robid,
    output ldq_pkg::t_pdst   req_pdst,
    output ldq_pkg::t_xdata  req_vaddr
);
    import ldq_pkg::*;

    logic    sent;
    t_rob_id robid;
    t_pdst   pdst;
    t_xdata  vaddr;

    logic    kill;
    logic    alloc_kill;
    logic    free;

    // Nuke hits this load or anything younger.
    assign kill       = nuke_valid && (robid >= nuke_robid);
    assign alloc_kill = nuke_valid && (alloc_robid >= nuke_robid);

    assign free = mm5_valid && (mm5_ldqid == id); // Completed or faulted at mm5.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= 1'b0;
        end else if (alloc) begin
            valid <= !alloc_kill; // A load issued under its own nuke is dropped.
        end else if (kill || free) begin
            valid <= 1'b0;
        end
    end

    // Set once the pipe has taken the load, so it asks only once.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sent <= 1'b0;
        end else if (alloc) begin
            sent <= 1'b0;
        end else if (gnt) begin
            sent <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            robid <= alloc_robid;
            pdst  <= alloc_pdst;
            vaddr <= alloc_vaddr;
        end
    end

    assign req       = valid && !sent;
    assign req_robid = robid;
    assign req_pdst  = pdst;
    assign req_vaddr = vaddr;

endmodule

// File: rtl/loadq.sv
`timescale 1ns/1ps
`include "ldq_defs.svh"

module loadq (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             iss_valid,
    input  ldq_pkg::t_ldq_id iss_ldqid,
    input  ldq_pkg::t_rob_id iss_robid,
    input  ldq_pkg::t_pdst   iss_pdst,
    input  ldq_pkg::t_xdata  iss_src1,
    input  ldq_pkg::t_xdata  iss_src2,
    input  logic             nuke_valid,
    input  ldq_pkg::t_rob_id nuke_robid,
    mem_pipe_if.queue        pipe
);
    import ldq_pkg::*;

    logic [`LDQ_NUM_ENTRIES-1:0] alloc_vec;
    t_xdata                      alloc_vaddr;

    logic [`LDQ_NUM_ENTRIES-1:0] e_valid;
    logic [`LDQ_NUM_ENTRIES-1:0] e_req;
    t_rob_id                     e_req_robid [`LDQ_NUM_ENTRIES];
    t_pdst                       e_req_pdst [`LDQ_NUM_ENTRIES];
    t_xdata                      e_req_vaddr [`LDQ_NUM_ENTRIES];
    logic [`LDQ_NUM_ENTRIES-1:0] e_gnt;

    logic                        mm5_free;

    assign alloc_vec   = iss_valid ? (`LDQ_NUM_ENTRIES'(1) << iss_ldqid) : '0;
    assign alloc_vaddr = iss_src1 + iss_src2; // Base plus offset.

    // Only a live entry with a real outcome is released.
    assign mm5_free = pipe.mm5_valid && (pipe.mm5_action != act_none)
                      && e_valid[pipe.mm5_ldqid];

    for (genvar e = 0; e < `LDQ_NUM_ENTRIES; e++) begin : g_entries
        loadq_entry u_entry (
            .clk         (clk),
            .rst_n       (rst_n),
            .id          (t_ldq_id'(e)),
            .alloc       (alloc_vec[e]),
            .alloc_robid (iss_robid),
            .alloc_pdst  (iss_pdst),
            .alloc_vaddr (alloc_vaddr),
            .nuke_valid  (nuke_valid),
            .nuke_robid  (nuke_robid),
            .gnt         (e_gnt[e]),
            .mm5_valid   (mm5_free),
            .mm5_ldqid   (pipe.mm5_ldqid),
            .valid       (e_valid[e]),
            .req         (e_req[e]),
            .req_robid   (e_req_robid[e]),
            .req_pdst    (e_req_pdst[e]),
            .req_vaddr   (e_req_vaddr[e])
        );
    end

    find_first_arbiter u_arb (
        .reqs       (e_req),
        .req_robids (e_req_robid),
        .req_pdsts  (e_req_pdst),
        .req_vaddrs (e_req_vaddr),
        .ext_gnt    (pipe.gnt),
        .ext_req    (pipe.req),
        .ext_ldqid  (pipe.req_ldqid),
        .ext_robid  (pipe.req_robid),
        .ext_pdst   (pipe.req_pdst),
        .ext_vaddr  (pipe.req_vaddr),
        .gnts       (e_gnt)
    );

endmodule

// File: rtl/mem_pipe.sv
`timescale 1ns/1ps
`include "ldq_defs.svh"

module mem_pipe (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           stall,
    input  logic                           nuke_valid,
    input  ldq_pkg::t_rob_id               nuke_robid,
    input  logic                           mem_wr_en,
    input  logic [$clog2(`DMEM_WORDS)-1:0] mem_wr_addr,
    input  ldq_pkg::t_xdata                mem_wr_data,
    mem_pipe_if.pipe                       pipe,
    output logic                           done_valid,
    output ldq_pkg::t_rob_id               done_robid,
    output ldq_pkg::t_pdst                 done_pdst,
    output ldq_pkg::t_xdata                done_data,
    output logic                           done_fault
);
    import ldq_pkg::*;

    localparam int DMEM_AW = $clog2(`DMEM_WORDS);

    logic         st_valid [mm1:mm5];
    t_ldq_id      st_ldqid [mm1:mm5];
    t_rob_id      st_robid [mm1:mm5];
    t_pdst        st_pdst [mm1:mm5];
    t_xdata       st_vaddr [mm1:mm5];

    t_xdata       dmem [`DMEM_WORDS];

    logic         enter;
    logic         mm5_live;
    logic         mm5_bad;
    t_pipe_action mm5_action;

    function automatic logic is_nuked(t_rob_id robid);
        return nuke_valid && (robid >= nuke_robid);
    endfunction

    assign pipe.gnt = pipe.req && !stall;
    assign enter    = pipe.req && pipe.gnt && !is_nuked(pipe.req_robid);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = mm1; s <= mm5; s++) begin
                st_valid[s] <= 1'b0;
            end
        end else begin
            st_valid[mm1] <= enter;
            for (int s = mm2; s <= mm5; s++) begin
                st_valid[s] <= st_valid[s-1] && !is_nuked(st_robid[s-1]); // Drop nuked loads.
            end
        end
    end

    always_ff @(posedge clk) begin
        st_ldqid[mm1] <= pipe.req_ldqid;
        st_robid[mm1] <= pipe.req_robid;
        st_pdst[mm1]  <= pipe.req_pdst;
        st_vaddr[mm1] <= pipe.req_vaddr;
        for (int s = mm2; s <= mm5; s++) begin
            st_ldqid[s] <= st_ldqid[s-1];
            st_robid[s] <= st_robid[s-1];
            st_pdst[s]  <= st_pdst[s-1];
            st_vaddr[s] <= st_vaddr[s-1];
        end
    end

    always_ff @(posedge clk) begin
        if (mem_wr_en) begin
            dmem[mem_wr_addr] <= mem_wr_data;
        end
    end

    // Misaligned or past the end of the data memory.
    assign mm5_bad = (st_vaddr[mm5][1:0] != 2'b00)
                     || (st_vaddr[mm5] >= t_xdata'(`DMEM_WORDS * 4));

    assign mm5_live   = st_valid[mm5] && !is_nuked(st_robid[mm5]);
    assign mm5_action = !mm5_live ? act_none : (mm5_bad ? act_fault : act_complete);

    assign pipe.mm5_valid  = mm5_live;
    assign pipe.mm5_ldqid  = st_ldqid[mm5];
    assign pipe.mm5_action = mm5_action;

    assign done_valid = mm5_live;
    assign done_robid = st_robid[mm5];
    assign done_pdst  = st_pdst[mm5];
    assign done_fault = (mm5_action == act_fault);
    assign done_data  = (mm5_action == act_complete) ? dmem[st_vaddr[mm5][DMEM_AW+1:2]] : '0;

endmodule

// File: rtl/load_unit.sv
`timescale 1ns/1ps
`include "ldq_defs.svh"

module load_unit (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           iss_valid,
    input  ldq_pkg::t_ldq_id               iss_ldqid,
    input  ldq_pkg::t_rob_id               iss_robid,
    input  ldq_pkg::t_pdst                 iss_pdst,
    input  ldq_pkg::t_xdata                iss_src1,
    input  ldq_pkg::t_xdata                iss_src2,
    input  logic                           nuke_valid,
    input  ldq_pkg::t_rob_id               nuke_robid,
    input  logic                           stall,
    input  logic                           mem_wr_en,
    input  logic [$clog2(`DMEM_WORDS)-1:0] mem_wr_addr,
    input  ldq_pkg::t_xdata                mem_wr_data,
    output logic                           done_valid,
    output ldq_pkg::t_rob_id               done_robid,
    output ldq_pkg::t_pdst                 done_pdst,
    output ldq_pkg::t_xdata                done_data,
    output logic                           done_fault
);

    mem_pipe_if u_pipe_if ();

    loadq u_loadq (
        .clk        (clk),
        .rst_n      (rst_n),
        .iss_valid  (iss_valid),
        .iss_ldqid  (iss_ldqid),
        .iss_robid  (iss_robid),
        .iss_pdst   (iss_pdst),
        .iss_src1   (iss_src1),
        .iss_src2   (iss_src2),
        .nuke_valid (nuke_valid),
        .nuke_robid (nuke_robid),
        .pipe       (u_pipe_if.queue)
    );

    // Both blocks see the same nuke in the same cycle.
    mem_pipe u_mem_pipe (
        .clk         (clk),
        .rst_n       (rst_n),
        .stall       (stall),
        .nuke_valid  (nuke_valid),
        .nuke_robid  (nuke_robid),
        .mem_wr_en   (mem_wr_en),
        .mem_wr_addr (mem_wr_addr),
        .mem_wr_data (mem_wr_data),
        .pipe        (u_pipe_if.pipe),
        .done_valid  (done_valid),
        .done_robid  (done_robid),
        .done_pdst   (done_pdst),
        .done_data   (done_data),
        .done_fault  (done_fault)
    );

endmodule

// File: tests/load_unit_assert.sv
`timescale 1ns/1ps
`include "ldq_defs.svh"

module load_unit_assert (
    input logic                        clk,
    input logic                        rst_n,
    input logic                        gnt,
    input logic                        stall,
    input logic                        done_valid,
    input logic [`LDQ_NUM_ENTRIES-1:0] gnt_vec,
    input logic [`LDQ_NUM_ENTRIES-1:0] entry_valid,
    input logic                        mm5_valid,
    input ldq_pkg::t_ldq_id            mm5_ldqid
);

    int fail_count = 0;

    gnt_not_stalled: assert property (@(posedge clk) disable iff (!rst_n) !(gnt && stall))
        else begin
            fail_count++;
            $error("Pipe granted a request while stalled.");
        end

    gnt_one_hot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(gnt_vec))
        else begin
            fail_count++;
            $error("More than one queue entry granted.");
        end

    // The mm5 result must always free a live entry.
    mm5_live_entry: assert property (@(posedge clk) disable iff (!rst_n)
        mm5_valid |-> entry_valid[mm5_ldqid])
        else begin
            fail_count++;
            $error("Pipe result names a queue entry that is not valid.");
        end

    done_quiet_in_reset: assert property (@(posedge clk) !rst_n |-> !done_valid)
        else begin
            fail_count++;
            $error("Done strobe high during reset.");
        end

endmodule

// File: tests/load_unit_checker.sv
`timescale 1ns/1ps
`include "ldq_defs.svh"

module load_unit_checker (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           iss_valid,
    input  ldq_pkg::t_ldq_id               iss_ldqid,
    input  ldq_pkg::t_rob_id               iss_robid,
    input  ldq_pkg::t_pdst                 iss_pdst,
    input  ldq_pkg::t_xdata                iss_src1,
    input  ldq_pkg::t_xdata                iss_src2,
    input  logic                           nuke_valid,
    input  ldq_pkg::t_rob_id               nuke_robid,
    input  logic                           stall,
    input  logic                           mem_wr_en,
    input  logic [$clog2(`DMEM_WORDS)-1:0] mem_wr_addr,
    input  ldq_pkg::t_xdata                mem_wr_data,
    input  logic                           done_valid,
    input  ldq_pkg::t_rob_id               done_robid,
    input  ldq_pkg::t_pdst                 done_pdst,
    input  ldq_pkg::t_xdata                done_data,
    input  logic                           done_fault,
    output logic [`LDQ_NUM_ENTRIES-1:0]    busy,
    output int                             pending,
    output int                             value_errs,
    output int                             flow_errs
);
    import ldq_pkg::*;

    localparam int AW = $clog2(`DMEM_WORDS);

    string   test_name;
    t_xdata  mem [`DMEM_WORDS]; // Mirror of the data memory.
    int      cycle_count;

    // Outstanding loads in issue order.
    string   q_name[$];
    t_ldq_id q_ldqid[$];
    t_rob_id q_robid[$];
    t_pdst   q_pdst[$];
    t_xdata  q_data[$];
    logic    q_fault[$];
    int      q_cycle[$];
    logic    q_clean[$]; // No contention or stall seen.

    initial begin
        busy = '0;
        pending = 0;
        value_errs = 0;
        flow_errs = 0;
        cycle_count = 0;
    end

    task automatic compare_field(input string name, input string what,
                                 input t_xdata exp, input t_xdata act);
        if (exp !== act) begin
            value_errs++;
            $display("** Error %0s expected %0s %0h actual %0h", name, what, exp, act);
        end
    endtask

    task automatic drop_prediction(input int i);
        busy[q_ldqid[i]] = 1'b0;
        q_name.delete(i);
        q_ldqid.delete(i);
        q_robid.delete(i);
        q_pdst.delete(i);
        q_data.delete(i);
        q_fault.delete(i);
        q_cycle.delete(i);
        q_clean.delete(i);
    endtask

    always @(posedge clk) begin : watch
        t_xdata vaddr;
        logic   fault;
        int     hit;
        if (rst_n) begin
            cycle_count++;
            if (stall) begin
                foreach (q_clean[i]) begin
                    q_clean[i] = 1'b0;
                end
            end
            // A nuke also silences the load at mm5 in the same cycle.
            if (nuke_valid) begin
                for (int i = q_robid.size() - 1; i >= 0; i--) begin
                    if (q_robid[i] >= nuke_robid) drop_prediction(i); // Younger loads die.
                end
            end
            if (done_valid) begin
                hit = -1;
                foreach (q_robid[i]) begin
                    if (q_robid[i] == done_robid) hit = i;
                end
                if (hit < 0) begin
                    flow_errs++;
                    $display("Extra completion for robid %0d at cycle %0d", done_robid,
                             cycle_count);
                end else begin
                    compare_field(q_name[hit], "pdst", t_xdata'(q_pdst[hit]), t_xdata'(done_pdst));
                    compare_field(q_name[hit], "data", q_data[hit], done_data);
                    compare_field(q_name[hit], "fault", t_xdata'(q_fault[hit]),
                                  t_xdata'(done_fault));
                    if (q_clean[hit]) begin
                        compare_field(q_name[hit], "latency", 32'd6,
                                      t_xdata'(cycle_count - q_cycle[hit]));
                    end
                    drop_prediction(hit);
                end
            end
            if (iss_valid) begin
                if (busy[iss_ldqid]) begin
                    flow_errs++;
                    $display("Load issued to queue id %0d while it was still busy", iss_ldqid);
                end
                // A load issued under its own nuke never starts.
                if (!(nuke_valid && (iss_robid >= nuke_robid))) begin
                    vaddr = iss_src1 + iss_src2;
                    fault = (vaddr[1:0] != 2'b00) || (vaddr >= t_xdata'(`DMEM_WORDS * 4));
                    q_clean.push_back(q_robid.size() == 0); // Alone in the unit.
                    q_name.push_back(test_name);
                    q_ldqid.push_back(iss_ldqid);
                    q_robid.push_back(iss_robid);
                    q_pdst.push_back(iss_pdst);
                    q_data.push_back(fault ? '0 : mem[vaddr[AW+1:2]]);
                    q_fault.push_back(fault);
                    q_cycle.push_back(cycle_count);
                    busy[iss_ldqid] = 1'b1;
                end
            end
            if (mem_wr_en) mem[mem_wr_addr] = mem_wr_data;
            pending = q_robid.size();
        end
    end

endmodule

// File: tests/load_unit_tb.sv
`timescale 1ns/1ps
`include "ldq_defs.svh"

module load_unit_tb;
    import ldq_pkg::*;

    localparam int AW = $clog2(`DMEM_WORDS);

    typedef struct packed {
        t_ldq_id ldqid;
        t_rob_id robid;
        t_pdst   pdst;
        t_xdata  src1;
        t_xdata  src2;
        int      stall_cycles;
        logic    nuke;
        t_rob_id nuke_robid;
        logic    refill;
    } t_row;

    logic                        clk = 1'b0;
    logic                        rst_n;
    logic                        iss_valid;
    t_ldq_id                     iss_ldqid;
    t_rob_id                     iss_robid;
    t_pdst                       iss_pdst;
    t_xdata                      iss_src1;
    t_xdata                      iss_src2;
    logic                        nuke_valid;
    t_rob_id                     nuke_robid;
    logic                        stall;
    logic                        mem_wr_en;
    logic [AW-1:0]               mem_wr_addr;
    t_xdata                      mem_wr_data;
    logic                        done_valid;
    t_rob_id                     done_robid;
    t_pdst                       done_pdst;
    t_xdata                      done_data;
    logic                        done_fault;
    logic [`LDQ_NUM_ENTRIES-1:0] busy;
    int                          pending;
    int                          value_errs;
    int                          flow_errs;
    int                          assert_errs;
    int                          cycle_count = 0;
    int                          cycle_limit = 0;
    integer                      seed;
    t_row                        rows[$];
    string                       names[$];

    load_unit UUT (.*);

    load_unit_checker u_checker (.*);

    // The queue side sees no stall or done strobe.
    bind loadq load_unit_assert u_assert (
        .clk(clk), .rst_n(rst_n), .gnt(pipe.gnt), .stall(1'b0), .done_valid(1'b0),
        .gnt_vec(e_gnt), .entry_valid(e_valid), .mm5_valid(pipe.mm5_valid),
        .mm5_ldqid(pipe.mm5_ldqid)
    );
    bind mem_pipe load_unit_assert u_assert (
        .clk(clk), .rst_n(rst_n), .gnt(pipe.gnt), .stall(stall), .done_valid(done_valid),
        .gnt_vec('0), .entry_valid('0), .mm5_valid(1'b0), .mm5_ldqid('0)
    );

    assign assert_errs = UUT.u_loadq.u_assert.fail_count + UUT.u_mem_pipe.u_assert.fail_count;

    initial begin
        forever #4 clk = ~clk;
    end

    always @(posedge clk) cycle_count <= cycle_count + 1;

    initial begin
        wait (cycle_limit > 0 && cycle_count >= cycle_limit);
        $display("Timeout after %0d cycles with %0d loads never completed", cycle_count, pending);
        $display("Errors: %0d value, %0d completion, %0d assertion", value_errs, flow_errs,
                 assert_errs);
        $display("Finished with errors");
        $finish;
    end

    task automatic add_row(input string name, input int id, input int robid, input int pdst,
                           input int src1, input int src2, input int stall_cyc,
                           input int nuke_rob, input bit refill);
        t_row r;
        r.ldqid = t_ldq_id'(id);
        r.robid = t_rob_id'(robid);
        r.pdst = t_pdst'(pdst);
        r.src1 = t_xdata'(src1);
        r.src2 = t_xdata'(src2);
        r.stall_cycles = stall_cyc;
        r.nuke = (nuke_rob >= 0);
        r.nuke_robid = t_rob_id'(nuke_rob);
        r.refill = refill;
        rows.push_back(r);
        names.push_back(name);
    endtask

    task automatic fill_memory;
        for (int w = 0; w < `DMEM_WORDS; w++) begin
            mem_wr_en = 1'b1;
            mem_wr_addr = AW'(w);
            mem_wr_data = $random(seed);
            @(negedge clk);
        end
        mem_wr_en = 1'b0;
    endtask

    task automatic apply_row(input int n);
        t_row r;
        r = rows[n];
        if (r.refill) begin
            while (pending != 0) @(negedge clk); // Pipe must be empty before rewriting.
            fill_memory();
        end
        while (busy[r.ldqid]) @(negedge clk);
        u_checker.test_name = names[n];
        iss_valid = 1'b1;
        iss_ldqid = r.ldqid;
        iss_robid = r.robid;
        iss_pdst = r.pdst;
        iss_src1 = r.src1;
        iss_src2 = r.src2;
        nuke_valid = r.nuke;
        nuke_robid = r.nuke_robid;
        stall = (r.stall_cycles > 0);
        @(negedge clk);
        iss_valid = 1'b0;
        nuke_valid = 1'b0;
        repeat (r.stall_cycles - 1) @(negedge clk);
        stall = 1'b0;
    endtask

    initial begin
        seed = 32'hd46d_8359;
        rst_n = 1'b0;
        iss_valid = 1'b0;
        iss_ldqid = '0;
        iss_robid = '0;
        iss_pdst = '0;
        iss_src1 = '0;
        iss_src2 = '0;
        nuke_valid = 1'b0;
        nuke_robid = '0;
        stall = 1'b0;
        mem_wr_en = 1'b0;
        mem_wr_addr = '0;
        mem_wr_data = '0;

        // Name, id, robid, pdst, src1, src2, stall cycles, nuke robid or -1, refill.
        add_row("single_aligned", 0, 1, 10, 'h10, 'h4, 0, -1, 0);
        add_row("single_word0", 0, 2, 11, 'h0, 'h0, 0, -1, 0);
        add_row("misaligned", 0, 3, 12, 'h21, 'h0, 0, -1, 0);
        add_row("out_of_range", 0, 4, 13, 'h3c, 'h8, 0, -1, 0);
        for (int i = 0; i < 8; i++) begin
            add_row("burst", i, 5 + i, 20 + i, 4 * i, 'h4, 0, -1, 0);
        end
        for (int i = 0; i < 8; i++) begin
            add_row("stall_burst", i, 13 + i, 30 + i, 'h3c, -4 * i, (i == 2) ? 6 : 0, -1, 0);
        end
        // Start from an empty pipe so the nuke meets loads in every stage, mm5 included.
        for (int i = 0; i < 8; i++) begin
            add_row("nuke_burst", i, 21 + i, 40 + i, 8 * i, 'h0, 0, (i == 7) ? 22 : -1, i == 0);
        end
        for (int i = 0; i < 8; i++) begin
            add_row("reissue", i % 4, 29 + i, 50 + i, 4 * (i % 4), 'h0, 0, -1, i % 4 == 0);
        end
        cycle_limit = rows.size() * 20 + 100;

        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        fill_memory();
        for (int n = 0; n < rows.size(); n++) begin
            apply_row(n);
        end
        while (pending != 0) @(negedge clk);
        repeat (20) @(negedge clk); // Late extra completions show up here.

        $display("Errors: %0d value, %0d completion, %0d assertion", value_errs, flow_errs,
                 assert_errs);
        if (value_errs + flow_errs + assert_errs == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: src.f
+incdir+rtl
rtl/ldq_pkg.sv
rtl/mem_pipe_if.sv
rtl/find_first_arbiter.sv
rtl/loadq_entry.sv
rtl/loadq.sv
rtl/mem_pipe.sv
rtl/load_unit.sv
tests/load_unit_assert.sv
tests/load_unit_checker.sv
tests/load_unit_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= load_unit_tb
FLIST     ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out=$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
